/* list.f */
+incdir+testbench
rtl/heapPkg.sv
rtl/heapOpIf.sv
rtl/requestPort.sv
rtl/arrayAllocator.sv
rtl/arrayEngine.sv
rtl/responsePort.sv
rtl/heapUnit.sv
testbench/heapUnitTb.sv

/* rtl/arrayAllocator.sv */
//--------------------
// Allocation flags, LIFO of freed arrays and the fresh-array counter.
// take and releaseReq are never high together; release of an
// unallocated array is filtered out by the engine.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module arrayAllocator (
  input  logic            clock,
  input  logic            reset,
  input  logic            take,
  input  logic            releaseReq,
  input  heapPkg::arrayId releaseId,
  input  heapPkg::arrayId lookupId,
  output heapPkg::arrayId grantId,
  output logic            grantAvailable,
  output logic            allocated
);

  logic [heapPkg::arrayCount-1:0]  allocFlags;                    // One per array
  heapPkg::arrayId                 freedStack [heapPkg::arrayCount];
  logic [heapPkg::addressBits:0]   freedTop;                      // Entries on the stack
  logic [heapPkg::addressBits:0]   freshCount;                    // Arrays never used yet
  heapPkg::arrayId                 topIndex;
  logic                            haveFreed;

  assign haveFreed = freedTop != '0;
  assign topIndex  = heapPkg::arrayId'(freedTop - 1'b1);

  // Freed arrays are reused before fresh ones
  assign grantId        = haveFreed ? freedStack[topIndex]
                                    : freshCount[heapPkg::addressBits-1:0];
  assign grantAvailable = haveFreed || (freshCount < heapPkg::arrayCount);
  assign allocated      = allocFlags[lookupId];

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocFlags <= '0;
      freedTop   <= '0;
      freshCount <= '0;
    end else begin
      if (take && grantAvailable) begin
        allocFlags[grantId] <= 1'b1;
        if (haveFreed)
          freedTop <= freedTop - 1'b1;      // Pop the freed stack
        else
          freshCount <= freshCount + 1'b1;
      end
      if (releaseReq) begin
        allocFlags[releaseId] <= 1'b0;      // Flag of the freed array itself
        freedTop              <= freedTop + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (releaseReq)
      freedStack[freedTop[heapPkg::addressBits-1:0]] <= releaseId;
  end

  // Holds only while the engine rejects frees of unallocated arrays
  stackBound: assert property (@(posedge clock) disable iff (!reset)
    freedTop <= heapPkg::arrayCount);

endmodule

`default_nettype wire

/* rtl/arrayEngine.sv */
//--------------------
// Executes one operation per valid strobe; response is registered.
// Failed operations leave memory, sizes and allocation untouched.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module arrayEngine (
  input  logic                 clock,
  input  logic                 reset,
  heapOpIf.executor            op,
  output logic                 respValid,
  output heapPkg::heapResponse response
);

  heapPkg::element      elementMem [heapPkg::arrayCount][heapPkg::arrayLength];
  heapPkg::arraySize    sizes [heapPkg::arrayCount];
  heapPkg::arraySize    currentSize;
  heapPkg::elementIndex lastIndex;      // Top element for Pop
  heapPkg::element      stored;         // Element at op.index
  heapPkg::element      sum;
  heapPkg::heapResponse respNext;
  heapPkg::arrayId      grantId;
  heapPkg::arrayId      sizeId;
  heapPkg::arraySize    sizeValue;
  heapPkg::elementIndex memIndex;
  heapPkg::element      memValue;
  logic                 grantAvailable;
  logic                 allocated;
  logic                 take;
  logic                 releaseReq;
  logic                 memWrite;
  logic                 sizeWrite;
  logic                 inBounds;

  arrayAllocator allocator (
    .clock          (clock),
    .reset          (reset),
    .take           (take),
    .releaseReq     (releaseReq),
    .releaseId      (op.array),
    .lookupId       (op.array),
    .grantId        (grantId),
    .grantAvailable (grantAvailable),
    .allocated      (allocated)
  );

  assign currentSize = sizes[op.array];
  assign lastIndex   = heapPkg::elementIndex'(currentSize - 1'b1);
  assign stored      = elementMem[op.array][op.index];
  assign sum         = stored + op.data;                     // Wraps at dataBits
  assign inBounds    = heapPkg::arraySize'(op.index) < currentSize;

  // Decode ---------------
  always_comb begin
    respNext.data  = '0;
    respNext.error = heapPkg::errNone;
    take       = 1'b0;
    releaseReq = 1'b0;
    memWrite   = 1'b0;
    memIndex   = op.index;
    memValue   = op.data;
    sizeWrite  = 1'b0;
    sizeId     = op.array;
    sizeValue  = currentSize;
    if (op.valid) begin
      if (op.action == heapPkg::opAlloc) begin
        if (grantAvailable) begin
          take          = 1'b1;
          sizeWrite     = 1'b1;
          sizeId        = grantId;                           // New array starts empty
          sizeValue     = '0;
          respNext.data = heapPkg::element'(grantId);
        end else begin
          respNext.error = heapPkg::errOutOfMemory;
        end
      end else if (!allocated) begin
        respNext.error = heapPkg::errNotAllocated;
      end else begin
        case (op.action)
          heapPkg::opFree: releaseReq = 1'b1;
          heapPkg::opWrite: begin
            memWrite      = 1'b1;
            respNext.data = op.data;
            if (!inBounds) begin                             // Grow up to index
              sizeWrite = 1'b1;
              sizeValue = heapPkg::arraySize'(op.index) + 1'b1;
            end
          end
          heapPkg::opRead: begin
            if (inBounds)
              respNext.data = stored;
            else
              respNext.error = heapPkg::errOutOfBounds;
          end
          heapPkg::opSize: respNext.data = heapPkg::element'(currentSize);
          heapPkg::opPush: begin
            if (currentSize < heapPkg::arrayLength) begin
              memWrite  = 1'b1;
              memIndex  = currentSize[heapPkg::indexBits-1:0];
              sizeWrite = 1'b1;
              sizeValue = currentSize + 1'b1;
            end else begin
              respNext.error = heapPkg::errFull;
            end
          end
          heapPkg::opPop: begin
            if (currentSize != '0) begin
              sizeWrite     = 1'b1;
              sizeValue     = currentSize - 1'b1;
              respNext.data = elementMem[op.array][lastIndex];
            end else begin
              respNext.error = heapPkg::errEmpty;
            end
          end
          heapPkg::opAdd: begin
            if (inBounds) begin
              memWrite      = 1'b1;
              memValue      = sum;
              respNext.data = sum;
            end else begin
              respNext.error = heapPkg::errOutOfBounds;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // State ----------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      respValid <= 1'b0;
      for (int i = 0; i < heapPkg::arrayCount; i++)
        sizes[i] <= '0;
    end else begin
      respValid <= op.valid;                                 // Fixed one-cycle latency
      if (sizeWrite)
        sizes[sizeId] <= sizeValue;
    end
  end

  always_ff @(posedge clock) begin
    if (memWrite)
      elementMem[op.array][memIndex] <= memValue;
    if (op.valid)
      response <= respNext;
  end

  oneCycleLatency: assert property (@(posedge clock) disable iff (!reset)
    respValid == $past(op.valid));

endmodule

`default_nettype wire

/* rtl/heapOpIf.sv */
//--------------------
// One accepted operation, request side to engine.
// valid is a one-cycle strobe; there is no back-pressure.
//--------------------
`timescale 1ns/1ps
`default_nettype none

interface heapOpIf;

  logic                  valid;   // Single-cycle strobe
  heapPkg::heapAction    action;
  heapPkg::arrayId       array;
  heapPkg::elementIndex  index;
  heapPkg::element       data;

  modport issuer (
    output valid,
    output action,
    output array,
    output index,
    output data
  );

  modport executor (
    input valid,
    input action,
    input array,
    input index,
    input data
  );

endinterface

`default_nettype wire

/* rtl/heapPkg.sv */
//--------------------
// Sizes, opcodes, error codes and the request/response records.
// All arrays share one length; sizes are fixed at compile time.
//--------------------
`default_nettype none

package heapPkg;

  // Sizes --------------
  localparam int addressBits = 2;                  // Width of an array number
  localparam int indexBits   = 2;                  // Width of an element index
  localparam int dataBits    = 12;                 // Width of an element
  localparam int arrayCount  = 2 ** addressBits;   // Arrays in the store
  localparam int arrayLength = 2 ** indexBits;     // Elements per array

  typedef logic [addressBits-1:0] arrayId;
  typedef logic [indexBits-1:0]   elementIndex;
  typedef logic [indexBits:0]     arraySize;       // Holds arrayLength itself
  typedef logic [dataBits-1:0]    element;

  // Encodings ----------
  typedef enum logic [2:0] {
    opAlloc,
    opFree,
    opWrite,
    opRead,
    opSize,
    opPush,
    opPop,
    opAdd
  } heapAction;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,
    errOutOfBounds,
    errFull,
    errEmpty,
    errOutOfMemory
  } heapError;

  typedef struct packed {
    heapAction   action;
    arrayId      array;
    elementIndex index;
    element      data;
  } heapRequest;                                   // 19 bits

  typedef struct packed {
    element   data;
    heapError error;
  } heapResponse;                                  // 15 bits

endpackage

`default_nettype wire

/* rtl/heapUnit.sv */
//--------------------
// Array store behind a four-phase req/ack handshake.
// One operation in flight; ack rises two edges after req is taken.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module heapUnit (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 req,
  input  heapPkg::heapAction   action,
  input  heapPkg::arrayId      array,
  input  heapPkg::elementIndex index,
  input  heapPkg::element      dataIn,
  output logic                 ack,
  output heapPkg::element      dataOut,
  output heapPkg::heapError    error
);

  logic                 respValid;
  heapPkg::heapResponse response;

  heapOpIf opBus ();

  requestPort requestSide (
    .clock  (clock),
    .reset  (reset),
    .req    (req),
    .action (action),
    .array  (array),
    .index  (index),
    .dataIn (dataIn),
    .op     (opBus.issuer)
  );

  arrayEngine engine (
    .clock     (clock),
    .reset     (reset),
    .op        (opBus.executor),
    .respValid (respValid),
    .response  (response)
  );

  responsePort responseSide (
    .clock     (clock),
    .reset     (reset),
    .req       (req),
    .respValid (respValid),
    .response  (response),
    .ack       (ack),
    .dataOut   (dataOut),
    .error     (error)
  );

endmodule

`default_nettype wire

/* rtl/requestPort.sv */
//--------------------
// Front half of the four-phase handshake.
// Inputs must be stable while req is high; one operation per req pulse.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module requestPort (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 req,
  input  heapPkg::heapAction   action,
  input  heapPkg::arrayId      array,
  input  heapPkg::elementIndex index,
  input  heapPkg::element      dataIn,
  heapOpIf.issuer              op
);

  logic                busy;      // Request taken, waiting for req low
  logic                accept;
  heapPkg::heapRequest pending;   // Latched request fields

  assign accept = req && !busy;   // New request seen while idle

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      busy     <= 1'b0;
      op.valid <= 1'b0;
    end else begin
      op.valid <= accept;         // Strobe for exactly one cycle
      if (accept)
        busy <= 1'b1;
      else if (busy && !req)
        busy <= 1'b0;             // Return to zero seen
    end
  end

  always_ff @(posedge clock) begin
    if (accept)
      pending <= '{action: action, array: array, index: index, data: dataIn};
  end

  assign op.action = pending.action;
  assign op.array  = pending.array;
  assign op.index  = pending.index;
  assign op.data   = pending.data;

  // A second strobe would mean one req was issued twice
  singleStrobe: assert property (@(posedge clock) disable iff (!reset)
    op.valid |=> !op.valid);

endmodule

`default_nettype wire

/* rtl/responsePort.sv */
//--------------------
// Back half of the four-phase handshake.
// dataOut and error hold their value until the next response.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module responsePort (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 req,
  input  logic                 respValid,
  input  heapPkg::heapResponse response,
  output logic                 ack,
  output heapPkg::element      dataOut,
  output heapPkg::heapError    error
);

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      ack <= 1'b0;
    end else begin
      if (respValid)
        ack <= 1'b1;              // Result ready
      else if (ack && !req)
        ack <= 1'b0;              // User has released req
    end
  end

  always_ff @(posedge clock) begin
    if (respValid) begin
      dataOut <= response.data;
      error   <= response.error;
    end
  end

  // ack only answers a completed operation
  ackAfterResponse: assert property (@(posedge clock) disable iff (!reset)
    $rose(ack) |-> $past(respValid));

endmodule

`default_nettype wire

/* testbench/heapModel.svh */
//--------------------
// Reference model of the array store, LFSR source and compare tasks.
// Included inside the testbench module. Elements never written are X in the
// DUT, so their data is tracked as unknown and only the error is compared.
//--------------------
`ifndef HEAP_MODEL_SVH
`define HEAP_MODEL_SVH

logic [31:0]          lfsrState = 32'h20ba78ed;
int                   errorCount = 0;
int                   timeoutCount = 0;
logic                 allocModel [heapPkg::arrayCount];
heapPkg::arraySize    sizeModel  [heapPkg::arrayCount];
heapPkg::element      memModel   [heapPkg::arrayCount][heapPkg::arrayLength];
logic                 knownModel [heapPkg::arrayCount][heapPkg::arrayLength];
heapPkg::arrayId      freedModel [$];                  // Back is the last freed
int                   freshModel;

function automatic logic [31:0] nextLfsr(input logic [31:0] state);
  return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);   // Galois form
endfunction

function automatic logic [31:0] randomBits(input int count);
  logic [31:0] value;
  value = '0;
  for (int i = 0; i < count; i++) begin
    lfsrState = nextLfsr(lfsrState);                   // One step per bit
    value = {value[30:0], lfsrState[0]};
  end
  return value;
endfunction

task automatic resetModel();
  for (int a = 0; a < heapPkg::arrayCount; a++) begin
    allocModel[a] = 1'b0;
    sizeModel[a] = '0;
    for (int e = 0; e < heapPkg::arrayLength; e++)
      knownModel[a][e] = 1'b0;
  end
  freedModel.delete();
  freshModel = 0;
endtask

// Expected response, and the model state after the operation
task automatic predict(input heapPkg::heapAction act, input heapPkg::arrayId id,
                       input heapPkg::elementIndex idx, input heapPkg::element value,
                       output heapPkg::element expData, output heapPkg::heapError expErr,
                       output logic dataKnown);
  heapPkg::arrayId      grant;
  heapPkg::arraySize    size;
  heapPkg::elementIndex top;
  logic                 inRange;
  expData   = '0;
  expErr    = heapPkg::errNone;
  dataKnown = 1'b1;
  size      = sizeModel[id];
  inRange   = heapPkg::arraySize'(idx) < size;
  top       = heapPkg::elementIndex'(size - 1'b1);
  if (act == heapPkg::opAlloc) begin
    if (freedModel.size() > 0 || freshModel < heapPkg::arrayCount) begin
      if (freedModel.size() > 0) begin
        grant = freedModel.pop_back();                 // Last freed first
      end else begin
        grant = heapPkg::arrayId'(freshModel);
        freshModel++;
      end
      allocModel[grant] = 1'b1;
      sizeModel[grant]  = '0;
      expData = heapPkg::element'(grant);
    end else begin
      expErr = heapPkg::errOutOfMemory;
    end
  end else if (!allocModel[id]) begin
    expErr = heapPkg::errNotAllocated;
  end else begin
    case (act)
      heapPkg::opFree: begin
        allocModel[id] = 1'b0;
        freedModel.push_back(id);
      end
      heapPkg::opWrite: begin
        memModel[id][idx]   = value;
        knownModel[id][idx] = 1'b1;
        if (!inRange)
          sizeModel[id] = heapPkg::arraySize'(idx) + 1'b1;   // Grows to cover idx
        expData = value;
      end
      heapPkg::opRead: begin
        if (inRange) begin
          expData   = memModel[id][idx];
          dataKnown = knownModel[id][idx];
        end else begin
          expErr = heapPkg::errOutOfBounds;
        end
      end
      heapPkg::opSize: expData = heapPkg::element'(size);
      heapPkg::opPush: begin
        if (size < heapPkg::arrayLength) begin
          memModel[id][size[heapPkg::indexBits-1:0]]   = value;
          knownModel[id][size[heapPkg::indexBits-1:0]] = 1'b1;
          sizeModel[id] = size + 1'b1;
        end else begin
          expErr = heapPkg::errFull;
        end
      end
      heapPkg::opPop: begin
        if (size != '0) begin
          expData       = memModel[id][top];
          dataKnown     = knownModel[id][top];
          sizeModel[id] = size - 1'b1;
        end else begin
          expErr = heapPkg::errEmpty;
        end
      end
      default: begin                                   // Add
        if (inRange) begin
          memModel[id][idx] = memModel[id][idx] + value;   // Wraps at dataBits
          expData   = memModel[id][idx];
          dataKnown = knownModel[id][idx];
        end else begin
          expErr = heapPkg::errOutOfBounds;
        end
      end
    endcase
  end
endtask

// Compare tasks ------
task automatic checkData(input heapPkg::element expected, input heapPkg::element actual);
  if (actual !== expected) begin
    errorCount++;
    $display("[FAIL] t=%0t dataOut expected %h got %h", $time, expected, actual);
  end
endtask

task automatic checkError(input heapPkg::heapError expected, input heapPkg::heapError actual);
  if (actual !== expected) begin
    errorCount++;
    $display("[FAIL] t=%0t error expected %0d got %0d", $time, expected, actual);
  end
endtask

task automatic checkFlag(input string name, input logic expected, input logic actual);
  if (actual !== expected) begin
    errorCount++;
    $display("[FAIL] t=%0t %s expected %b got %b", $time, name, expected, actual);
  end
endtask

task automatic checkCycles(input string name, input int expected, input int actual);
  if (actual != expected) begin
    errorCount++;
    $display("[FAIL] t=%0t %s expected %0d edges got %0d", $time, name, expected, actual);
  end
endtask

`endif

/* testbench/heapUnitTb.sv */
//--------------------
// Drives heapUnit through directed and random operations over req/ack.
// Inputs change on the falling edge; results are sampled there too.
//--------------------
`timescale 1ns/1ps
`default_nettype none

module heapUnitTb;

  localparam int riseEdges  = 3;       // Falling edges from req high to ack seen high
  localparam int fallEdges  = 1;       // Falling edges from req low to ack seen low
  localparam int waitLimit  = 20;
  localparam int randomOps  = 400;

  logic                 clock;
  logic                 reset;
  logic                 req;
  heapPkg::heapAction   action;
  heapPkg::arrayId      array;
  heapPkg::elementIndex index;
  heapPkg::element      dataIn;
  logic                 ack;
  heapPkg::element      dataOut;
  heapPkg::heapError    error;

  `include "heapModel.svh"

  heapUnit uut (
    .clock   (clock),
    .reset   (reset),
    .req     (req),
    .action  (action),
    .array   (array),
    .index   (index),
    .dataIn  (dataIn),
    .ack     (ack),
    .dataOut (dataOut),
    .error   (error)
  );

  always #5 clock = ~clock;

  task automatic finishRun();
    $display("errors=%0d timeouts=%0d", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  endtask

  // One full handshake; starts and ends on a falling edge with ack low
  task automatic runOp(input heapPkg::heapAction act, input heapPkg::arrayId id,
                       input heapPkg::elementIndex idx, input heapPkg::element value);
    heapPkg::element   expData;
    heapPkg::heapError expErr;
    logic              dataKnown;
    int                cycles;
    int                hold;
    if (timeoutCount != 0)
      return;                                          // Handshake already stuck
    action = act;
    array  = id;
    index  = idx;
    dataIn = value;
    req    = 1'b1;
    predict(act, id, idx, value, expData, expErr, dataKnown);
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
    end while (!ack && cycles < waitLimit);
    if (!ack) begin
      $display("Timeout: ack did not rise for action %0d on array %0d", act, id);
      timeoutCount++;
    end else begin
      checkCycles("ack rise", riseEdges, cycles);
      checkError(expErr, error);
      if (dataKnown)
        checkData(expData, dataOut);
      hold = randomBits(2);                            // Back-pressure with req held high
      repeat (hold) begin
        @(negedge clock);
        checkFlag("ack", 1'b1, ack);
        checkError(expErr, error);
        if (dataKnown)
          checkData(expData, dataOut);
      end
      req = 1'b0;
      cycles = 0;
      do begin
        @(negedge clock);
        cycles++;
      end while (ack && cycles < waitLimit);
      if (ack) begin
        $display("Timeout: ack stayed high after req dropped");
        timeoutCount++;
      end else begin
        checkCycles("ack fall", fallEdges, cycles);
      end
    end
  endtask

  function automatic heapPkg::heapAction pickAction(input int step);
    if (step < 80 && randomBits(1) == 1)
      return heapPkg::opAlloc;                         // Favor Alloc early on
    return heapPkg::heapAction'(randomBits(3));
  endfunction

  initial begin
    clock  = 1'b0;
    reset  = 1'b0;
    req    = 1'b0;
    action = heapPkg::opAlloc;
    array  = '0;
    index  = '0;
    dataIn = '0;
    resetModel();
    repeat (3) @(negedge clock);
    reset = 1'b1;

    // Idle and unallocated --------------------
    repeat (5) begin
      @(negedge clock);
      checkFlag("ack", 1'b0, ack);
    end
    for (int a = 1; a < 8; a++)
      runOp(heapPkg::heapAction'(a), 2'd0, 2'd1, 12'h055);

    // Allocation order and reuse --------------------
    for (int a = 0; a <= heapPkg::arrayCount; a++)
      runOp(heapPkg::opAlloc, '0, '0, '0);             // Last one runs out
    runOp(heapPkg::opFree, 2'd1, '0, '0);
    runOp(heapPkg::opFree, 2'd3, '0, '0);
    runOp(heapPkg::opAlloc, '0, '0, '0);
    runOp(heapPkg::opAlloc, '0, '0, '0);

    // Write, Read, Size
    runOp(heapPkg::opWrite, 2'd0, 2'd2, 12'hA5C);
    runOp(heapPkg::opRead, 2'd0, 2'd2, '0);
    runOp(heapPkg::opSize, 2'd0, '0, '0);
    runOp(heapPkg::opRead, 2'd0, 2'd3, '0);

    // Stack use of array 1
    for (int p = 0; p <= heapPkg::arrayLength; p++)
      runOp(heapPkg::opPush, 2'd1, '0, heapPkg::element'(12'h100 + p));
    for (int p = 0; p <= heapPkg::arrayLength; p++)
      runOp(heapPkg::opPop, 2'd1, '0, '0);

    // Add with wrap
    runOp(heapPkg::opWrite, 2'd2, 2'd0, 12'hFF0);
    runOp(heapPkg::opAdd, 2'd2, 2'd0, 12'h020);
    runOp(heapPkg::opRead, 2'd2, 2'd0, '0);

    // Random sequence --------------------
    for (int n = 0; n < randomOps; n++)
      runOp(pickAction(n),
            heapPkg::arrayId'(randomBits(heapPkg::addressBits)),
            heapPkg::elementIndex'(randomBits(heapPkg::indexBits)),
            heapPkg::element'(randomBits(heapPkg::dataBits)));

    finishRun();
  end

endmodule

`default_nettype wire
